/* rtl/msx_pkg.sv */
`default_nettype none

package msx_pkg;

   localparam int dump_bytes = 2048;
   localparam logic [27:0] ddr3_dump_base = 28'h1400000;

   localparam int memory_block_depth = 16;
   localparam int slot_depth         = 4;
   localparam int rom_depth          = 2;
   localparam int config_depth       = 16;
   localparam int fw_store_depth     = 8;

   typedef struct packed {
      logic [7:0]  typ;
      logic [7:0]  block_count;
      logic [23:0] mem_offset;
   } block_t;

   // One 16 KB page of a subslot.
   typedef struct packed {
      logic [7:0] init;
      logic [7:0] block_id;
      logic [7:0] offset;
   } slot_block_t;

   typedef struct packed {
      slot_block_t [3:0] block;
   } subslot_t;

   typedef struct packed {
      logic [7:0]     typ;
      subslot_t [3:0] subslot;
   } slot_t;

   typedef struct packed {
      logic [7:0]  mapper;
      logic [7:0]  offset;
      logic [23:0] size;
   } rom_info_t;

   typedef struct packed {
      logic [23:0] rom_size;
      logic [7:0]  rom_mapper;
      logic [7:0]  loaded;
   } ioctl_rom_t;

   typedef struct packed {
      logic [7:0]  typ;
      logic [7:0]  block_id;
      logic [7:0]  block_count;
      logic [7:0]  slot;
      logic [7:0]  sub_slot;
      logic [7:0]  slot_internal_mapper;
      logic [7:0]  start_block;
      logic [23:0] store_address;
   } msx_config_t;

   typedef struct packed {
      logic [7:0]  block_count;
      logic [23:0] store_address;
   } fw_rom_t;

endpackage

`default_nettype wire

/* rtl/msx_config_loader.sv */
`default_nettype none

module msx_config_loader (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 ioctl_wr,
   input  wire logic [10:0]          ioctl_addr,
   input  wire logic [7:0]           ioctl_dout,
   output msx_pkg::block_t           memory_block [msx_pkg::memory_block_depth],
   output msx_pkg::slot_t            msx_slot     [msx_pkg::slot_depth],
   output msx_pkg::rom_info_t        rom_info     [msx_pkg::rom_depth],
   output msx_pkg::ioctl_rom_t       ioctl_rom    [msx_pkg::rom_depth],
   output msx_pkg::msx_config_t      msx_config   [msx_pkg::config_depth],
   output msx_pkg::fw_rom_t          fw_store     [msx_pkg::fw_store_depth]
);

   logic [3:0] rec;
   logic [1:0] slot_idx;
   logic [1:0] sub_idx;
   logic       rom_hi;
   logic [7:0] rom_off;

   assign rec      = ioctl_addr[7:4];
   assign slot_idx = ioctl_addr[7:6];
   assign sub_idx  = ioctl_addr[5:4];

   // Region 2 packs two 10-byte entries back to back.
   always_comb begin
      rom_hi  = ioctl_addr[7:0] >= 8'd10;
      rom_off = rom_hi ? ioctl_addr[7:0] - 8'd10 : ioctl_addr[7:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         memory_block <= '{default: '0};
         msx_slot     <= '{default: '0};
         rom_info     <= '{default: '0};
         ioctl_rom    <= '{default: '0};
         msx_config   <= '{default: '0};
         fw_store     <= '{default: '0};
      end else if (ioctl_wr) begin
         case (ioctl_addr[10:8])
            3'd0: begin
               if (ioctl_addr[3:0] == 4'd1) msx_slot[slot_idx].typ <= ioctl_dout;
               // Bytes 0 and 2 are the slot and subslot numbers and are not stored.
               for (int b = 0; b < 4; b++) begin
                  if (ioctl_addr[3:0] == 4'(3 + 3 * b))
                     msx_slot[slot_idx].subslot[sub_idx].block[b].init <= ioctl_dout;
                  if (ioctl_addr[3:0] == 4'(4 + 3 * b))
                     msx_slot[slot_idx].subslot[sub_idx].block[b].block_id <= ioctl_dout;
                  if (ioctl_addr[3:0] == 4'(5 + 3 * b))
                     msx_slot[slot_idx].subslot[sub_idx].block[b].offset <= ioctl_dout;
               end
            end
            3'd1: begin
               case (ioctl_addr[3:0])
                  4'd0: memory_block[rec].typ               <= ioctl_dout;
                  4'd1: memory_block[rec].block_count       <= ioctl_dout;
                  4'd2: memory_block[rec].mem_offset[23:16] <= ioctl_dout;
                  4'd3: memory_block[rec].mem_offset[15:8]  <= ioctl_dout;
                  4'd4: memory_block[rec].mem_offset[7:0]   <= ioctl_dout;
                  default: ;
               endcase
            end
            3'd2: begin
               if (ioctl_addr[7:0] < 8'd20) begin
                  case (rom_off[3:0])
                     4'd0: rom_info[rom_hi].mapper          <= ioctl_dout;
                     4'd1: rom_info[rom_hi].offset          <= ioctl_dout;
                     4'd2: rom_info[rom_hi].size[23:16]     <= ioctl_dout;
                     4'd3: rom_info[rom_hi].size[15:8]      <= ioctl_dout;
                     4'd4: rom_info[rom_hi].size[7:0]       <= ioctl_dout;
                     4'd5: ioctl_rom[rom_hi].rom_size[23:16] <= ioctl_dout;
                     4'd6: ioctl_rom[rom_hi].rom_size[15:8]  <= ioctl_dout;
                     4'd7: ioctl_rom[rom_hi].rom_size[7:0]   <= ioctl_dout;
                     4'd8: ioctl_rom[rom_hi].rom_mapper      <= ioctl_dout;
                     4'd9: ioctl_rom[rom_hi].loaded          <= ioctl_dout;
                     default: ;
                  endcase
               end
            end
            3'd3: begin
               case (ioctl_addr[3:0])
                  4'd0: msx_config[rec].typ                  <= ioctl_dout;
                  4'd1: msx_config[rec].block_id             <= ioctl_dout;
                  4'd2: msx_config[rec].block_count          <= ioctl_dout;
                  4'd3: msx_config[rec].slot                 <= ioctl_dout;
                  4'd4: msx_config[rec].sub_slot             <= ioctl_dout;
                  4'd5: msx_config[rec].slot_internal_mapper <= ioctl_dout;
                  4'd6: msx_config[rec].start_block          <= ioctl_dout;
                  4'd7: msx_config[rec].store_address[23:16] <= ioctl_dout;
                  4'd8: msx_config[rec].store_address[15:8]  <= ioctl_dout;
                  4'd9: msx_config[rec].store_address[7:0]   <= ioctl_dout;
                  default: ;
               endcase
            end
            3'd4: begin
               if (ioctl_addr[7:5] == 3'd0) begin  // Only the first 32 bytes hold records.
                  case (ioctl_addr[1:0])
                     2'd0: fw_store[ioctl_addr[4:2]].block_count          <= ioctl_dout;
                     2'd1: fw_store[ioctl_addr[4:2]].store_address[23:16] <= ioctl_dout;
                     2'd2: fw_store[ioctl_addr[4:2]].store_address[15:8]  <= ioctl_dout;
                     2'd3: fw_store[ioctl_addr[4:2]].store_address[7:0]   <= ioctl_dout;
                  endcase
               end
            end
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/msx_download_debug.sv */
`default_nettype none

module msx_download_debug (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 dump_start,
   input  wire msx_pkg::block_t      memory_block [msx_pkg::memory_block_depth],
   input  wire msx_pkg::slot_t       msx_slot     [msx_pkg::slot_depth],
   input  wire msx_pkg::rom_info_t   rom_info     [msx_pkg::rom_depth],
   input  wire msx_pkg::ioctl_rom_t  ioctl_rom    [msx_pkg::rom_depth],
   input  wire msx_pkg::msx_config_t msx_config   [msx_pkg::config_depth],
   input  wire msx_pkg::fw_rom_t     fw_store     [msx_pkg::fw_store_depth],
   output logic [27:0]               byte_addr,
   output logic [7:0]                byte_data,
   output logic                      upload,
   output logic                      byte_wr,
   output logic                      done,
   input  wire logic                 byte_ready
);

   localparam logic [2:0] st_idle   = 3'd0;
   localparam logic [2:0] st_select = 3'd2;
   localparam logic [2:0] st_wait   = 3'd3;
   localparam logic [2:0] st_strobe = 3'd4;
   localparam logic [2:0] st_next   = 3'd5;

   logic [2:0]        state;
   logic [10:0]       addr;
   logic [7:0]        field;
   logic              rom_hi;
   logic [7:0]        rom_off;
   msx_pkg::subslot_t sub;

   assign byte_addr = msx_pkg::ddr3_dump_base + {17'd0, addr};

   // Byte of the image at the current counter value.
   always_comb begin
      rom_hi  = addr[7:0] >= 8'd10;
      rom_off = rom_hi ? addr[7:0] - 8'd10 : addr[7:0];
      sub     = msx_slot[addr[7:6]].subslot[addr[5:4]];
      field   = 8'd0;
      case (addr[10:8])
         3'd0: begin
            case (addr[3:0])
               4'd0: field = {6'd0, addr[7:6]};
               4'd1: field = msx_slot[addr[7:6]].typ;
               4'd2: field = {6'd0, addr[5:4]};
               default: ;
            endcase
            for (int b = 0; b < 4; b++) begin
               if (addr[3:0] == 4'(3 + 3 * b)) field = sub.block[b].init;
               if (addr[3:0] == 4'(4 + 3 * b)) field = sub.block[b].block_id;
               if (addr[3:0] == 4'(5 + 3 * b)) field = sub.block[b].offset;
            end
         end
         3'd1: begin
            case (addr[3:0])
               4'd0: field = memory_block[addr[7:4]].typ;
               4'd1: field = memory_block[addr[7:4]].block_count;
               4'd2: field = memory_block[addr[7:4]].mem_offset[23:16];
               4'd3: field = memory_block[addr[7:4]].mem_offset[15:8];
               4'd4: field = memory_block[addr[7:4]].mem_offset[7:0];
               default: ;
            endcase
         end
         3'd2: begin
            if (addr[7:0] < 8'd20) begin
               case (rom_off[3:0])
                  4'd0: field = rom_info[rom_hi].mapper;
                  4'd1: field = rom_info[rom_hi].offset;
                  4'd2: field = rom_info[rom_hi].size[23:16];
                  4'd3: field = rom_info[rom_hi].size[15:8];
                  4'd4: field = rom_info[rom_hi].size[7:0];
                  4'd5: field = ioctl_rom[rom_hi].rom_size[23:16];
                  4'd6: field = ioctl_rom[rom_hi].rom_size[15:8];
                  4'd7: field = ioctl_rom[rom_hi].rom_size[7:0];
                  4'd8: field = ioctl_rom[rom_hi].rom_mapper;
                  4'd9: field = ioctl_rom[rom_hi].loaded;
                  default: ;
               endcase
            end
         end
         3'd3: begin
            case (addr[3:0])
               4'd0: field = msx_config[addr[7:4]].typ;
               4'd1: field = msx_config[addr[7:4]].block_id;
               4'd2: field = msx_config[addr[7:4]].block_count;
               4'd3: field = msx_config[addr[7:4]].slot;
               4'd4: field = msx_config[addr[7:4]].sub_slot;
               4'd5: field = msx_config[addr[7:4]].slot_internal_mapper;
               4'd6: field = msx_config[addr[7:4]].start_block;
               4'd7: field = msx_config[addr[7:4]].store_address[23:16];
               4'd8: field = msx_config[addr[7:4]].store_address[15:8];
               4'd9: field = msx_config[addr[7:4]].store_address[7:0];
               default: ;
            endcase
         end
         3'd4: begin
            if (addr[7:5] == 3'd0) begin
               case (addr[1:0])
                  2'd0: field = fw_store[addr[4:2]].block_count;
                  2'd1: field = fw_store[addr[4:2]].store_address[23:16];
                  2'd2: field = fw_store[addr[4:2]].store_address[15:8];
                  2'd3: field = fw_store[addr[4:2]].store_address[7:0];
               endcase
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == st_select) byte_data <= field;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_idle;
         addr    <= 11'd0;
         upload  <= 1'b0;
         byte_wr <= 1'b0;
         done    <= 1'b0;
      end else begin
         done <= 1'b0;
         case (state)
            st_idle: begin
               if (dump_start) begin
                  addr  <= 11'd0;
                  state <= st_select;
               end
            end
            st_select: begin
               upload <= 1'b1;
               state  <= st_wait;
            end
            st_wait: begin
               if (byte_ready) begin
                  byte_wr <= 1'b1;
                  state   <= st_strobe;
               end
            end
            st_strobe: begin
               byte_wr <= 1'b0;
               state   <= st_next;
            end
            st_next: begin
               if (addr == 11'(msx_pkg::dump_bytes - 1)) begin
                  upload <= 1'b0;  // The packer flushes on this edge.
                  done   <= 1'b1;
                  state  <= st_idle;
               end else begin
                  addr  <= addr + 11'd1;
                  state <= st_select;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/ddr3_byte_packer.sv */
`default_nettype none

module ddr3_byte_packer #(
   parameter int word_bytes = 8
) (
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  wire logic [27:0]                       byte_addr,
   input  wire logic [7:0]                        byte_data,
   input  wire logic                              upload,
   input  wire logic                              byte_wr,
   output logic                                   byte_ready,
   output logic [27-$clog2(word_bytes):0]         ddr3_word_addr,
   output logic [8*word_bytes-1:0]                ddr3_din,
   output logic [word_bytes-1:0]                  ddr3_be,
   output logic                                   ddr3_we,
   input  wire logic                              ddr3_busy
);

   localparam int lane_bits = $clog2(word_bytes);

   logic [lane_bits-1:0] lane;
   logic                 upload_q;

   assign lane       = byte_addr[lane_bits-1:0];
   assign byte_ready = !ddr3_we;  // No new byte while a word is waiting.

   always_ff @(posedge clk) begin
      if (byte_wr) begin
         ddr3_din[8*lane +: 8] <= byte_data;
         ddr3_word_addr        <= byte_addr[27:lane_bits];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ddr3_we  <= 1'b0;
         ddr3_be  <= '0;
         upload_q <= 1'b0;
      end else begin
         upload_q <= upload;
         if (ddr3_we && !ddr3_busy) begin
            ddr3_we <= 1'b0;
            ddr3_be <= '0;
         end
         if (byte_wr) begin
            ddr3_be[lane] <= 1'b1;
            if (lane == (word_bytes - 1)) ddr3_we <= 1'b1;
         end else if (upload_q && !upload && !ddr3_we && ddr3_be != '0) begin
            ddr3_we <= 1'b1;  // Partial word left at the end of a dump.
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/msx_debug_dump.sv */
`default_nettype none

module msx_debug_dump #(
   parameter int word_bytes = 8
) (
   input  wire logic                              clk,
   input  wire logic                              reset,
   input  wire logic                              ioctl_wr,
   input  wire logic [10:0]                       ioctl_addr,
   input  wire logic [7:0]                        ioctl_dout,
   input  wire logic                              dump_start,
   output wire logic [27-$clog2(word_bytes):0]    ddr3_word_addr,
   output wire logic [8*word_bytes-1:0]           ddr3_din,
   output wire logic [word_bytes-1:0]             ddr3_be,
   output wire logic                              ddr3_we,
   input  wire logic                              ddr3_busy,
   output wire logic                              dump_done
);

   msx_pkg::block_t      memory_block [msx_pkg::memory_block_depth];
   msx_pkg::slot_t       msx_slot     [msx_pkg::slot_depth];
   msx_pkg::rom_info_t   rom_info     [msx_pkg::rom_depth];
   msx_pkg::ioctl_rom_t  ioctl_rom    [msx_pkg::rom_depth];
   msx_pkg::msx_config_t msx_config   [msx_pkg::config_depth];
   msx_pkg::fw_rom_t     fw_store     [msx_pkg::fw_store_depth];

   logic [27:0] byte_addr;
   logic [7:0]  byte_data;
   logic        upload;
   logic        byte_wr;
   logic        byte_ready;

   msx_config_loader i_msx_config_loader (
      .clk          (clk),
      .reset        (reset),
      .ioctl_wr     (ioctl_wr),
      .ioctl_addr   (ioctl_addr),
      .ioctl_dout   (ioctl_dout),
      .memory_block (memory_block),
      .msx_slot     (msx_slot),
      .rom_info     (rom_info),
      .ioctl_rom    (ioctl_rom),
      .msx_config   (msx_config),
      .fw_store     (fw_store)
   );

   msx_download_debug i_msx_download_debug (
      .clk          (clk),
      .reset        (reset),
      .dump_start   (dump_start),
      .memory_block (memory_block),
      .msx_slot     (msx_slot),
      .rom_info     (rom_info),
      .ioctl_rom    (ioctl_rom),
      .msx_config   (msx_config),
      .fw_store     (fw_store),
      .byte_addr    (byte_addr),
      .byte_data    (byte_data),
      .upload       (upload),
      .byte_wr      (byte_wr),
      .done         (dump_done),
      .byte_ready   (byte_ready)
   );

   ddr3_byte_packer #(
      .word_bytes (word_bytes)
   ) i_ddr3_byte_packer (
      .clk            (clk),
      .reset          (reset),
      .byte_addr      (byte_addr),
      .byte_data      (byte_data),
      .upload         (upload),
      .byte_wr        (byte_wr),
      .byte_ready     (byte_ready),
      .ddr3_word_addr (ddr3_word_addr),
      .ddr3_din       (ddr3_din),
      .ddr3_be        (ddr3_be),
      .ddr3_we        (ddr3_we),
      .ddr3_busy      (ddr3_busy)
   );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
`default_nettype none

module tb_clock (
   output logic clk,
   output logic reset
);

   localparam int half_period = 50;

   initial begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // Reset covers the first two rising edges and drops on a falling edge.
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

/* verification/tb_msx_debug_dump.sv */
`default_nettype none

module tb_msx_debug_dump;

   localparam int          image_bytes   = 2048;
   localparam int          word_count    = 256;
   localparam logic [24:0] first_word    = 25'h280000;  // Byte address 0x1400000 over 8.
   localparam int          dump_timeout  = 40000;
   localparam int          drain_timeout = 1000;
   localparam int          reset_timeout = 20;

   logic        clk;
   logic        reset;
   logic        ioctl_wr;
   logic [10:0] ioctl_addr;
   logic [7:0]  ioctl_dout;
   logic        dump_start;
   logic        ddr3_busy;
   logic [24:0] ddr3_word_addr;
   logic [63:0] ddr3_din;
   logic [7:0]  ddr3_be;
   logic        ddr3_we;
   logic        dump_done;

   integer      seed = 32'h8d3a;
   int          errors;
   int          pass_count;
   int          fail_count;
   bit          timed_out;
   logic [7:0]  exp_image  [image_bytes];
   logic [7:0]  mem_image  [image_bytes];
   logic [7:0]  prev_image [image_bytes];
   bit          changed    [image_bytes];
   int          word_seen  [word_count];
   int          word_total;
   int          stray_writes;
   int          partial_writes;
   int          order_errors;
   int          stalls;
   int          w_idx;
   bit          hold_valid;
   logic [24:0] hold_addr;
   logic [63:0] hold_din;
   logic [7:0]  hold_be;

   tb_clock i_tb_clock (
      .clk   (clk),
      .reset (reset)
   );

   msx_debug_dump #(
      .word_bytes (8)
   ) i_msx_debug_dump (
      .clk            (clk),
      .reset          (reset),
      .ioctl_wr       (ioctl_wr),
      .ioctl_addr     (ioctl_addr),
      .ioctl_dout     (ioctl_dout),
      .dump_start     (dump_start),
      .ddr3_word_addr (ddr3_word_addr),
      .ddr3_din       (ddr3_din),
      .ddr3_be        (ddr3_be),
      .ddr3_we        (ddr3_we),
      .ddr3_busy      (ddr3_busy),
      .dump_done      (dump_done)
   );

   // DDR3 memory model. A word lands on an edge where ddr3_we is high and ddr3_busy low.
   always @(posedge clk) begin
      if (hold_valid && ddr3_we) begin
         if (ddr3_din !== hold_din || ddr3_be !== hold_be || ddr3_word_addr !== hold_addr) begin
            $display("Mismatch at %0t: held word changed while ddr3_busy was high", $time);
            errors++;
         end
      end
      hold_valid = ddr3_we && ddr3_busy;
      hold_din   = ddr3_din;
      hold_be    = ddr3_be;
      hold_addr  = ddr3_word_addr;
      if (hold_valid) stalls++;
      if (ddr3_we && !ddr3_busy) begin
         w_idx = int'(ddr3_word_addr - first_word);
         if (w_idx >= 0 && w_idx < word_count) begin
            word_seen[w_idx]++;
            for (int l = 0; l < 8; l++) begin
               if (ddr3_be[l]) mem_image[w_idx * 8 + l] = ddr3_din[8 * l +: 8];
            end
         end else begin
            stray_writes++;
         end
         if (ddr3_be !== 8'hff) partial_writes++;
         if (ddr3_word_addr !== first_word + 25'(word_total)) order_errors++;
         word_total++;
      end
   end

   // True where the image map holds a loadable field.
   function automatic bit is_stored(input logic [10:0] a);
      case (a[10:8])
         3'd0: return a[3:0] != 4'd0 && a[3:0] != 4'd2 && a[3:0] != 4'd15;
         3'd1: return a[3:0] <= 4'd4;
         3'd2: return a[7:0] < 8'd20;
         3'd3: return a[3:0] <= 4'd9;
         3'd4: return a[7:5] == 3'd0;
         default: return 1'b0;
      endcase
   endfunction

   task automatic reset_expected();
      for (int i = 0; i < image_bytes; i++) begin
         exp_image[i] = 8'd0;
         if (i < 256 && i % 16 == 0) exp_image[i] = 8'(i / 64);  // Slot number.
         if (i < 256 && i % 16 == 2) exp_image[i] = 8'((i / 16) % 4);
      end
   endtask

   task automatic write_byte(input logic [10:0] a, input logic [7:0] d);
      @(negedge clk);
      ioctl_wr   = 1'b1;
      ioctl_addr = a;
      ioctl_dout = d;
      @(negedge clk);
      ioctl_wr = 1'b0;
      if (is_stored(a)) begin
         // The slot typ appears in all four subslot records of its slot.
         if (a[10:8] == 3'd0 && a[3:0] == 4'd1) begin
            for (int s = 0; s < 4; s++) begin
               exp_image[{a[10:6], 2'(s), 4'd1}] = d;
            end
         end else begin
            exp_image[a] = d;
         end
      end
   endtask

   task automatic clear_capture();
      for (int i = 0; i < image_bytes; i++) begin
         mem_image[i] = 8'(i * 37 + i / 256) ^ 8'h5c;
      end
      for (int w = 0; w < word_count; w++) begin
         word_seen[w] = 0;
      end
      word_total     = 0;
      stray_writes   = 0;
      partial_writes = 0;
      order_errors   = 0;
      stalls         = 0;
      hold_valid     = 1'b0;
   endtask

   task automatic run_dump(input bit with_busy);
      int          cycles;
      logic [31:0] rnd;
      clear_capture();
      @(negedge clk);
      dump_start = 1'b1;
      @(negedge clk);
      dump_start = 1'b0;
      cycles = 0;
      while (!dump_done && cycles < dump_timeout) begin
         if (with_busy) begin
            rnd       = $random(seed);
            ddr3_busy = rnd[0];
         end
         @(negedge clk);
         cycles++;
      end
      ddr3_busy = 1'b0;
      if (!dump_done) begin
         $display("Timeout at %0t: dump_done never pulsed", $time);
         timed_out = 1'b1;
         errors++;
      end else begin
         @(negedge clk);
         if (dump_done !== 1'b0) begin
            $display("Mismatch at %0t: dump_done stayed high for more than one cycle", $time);
            errors++;
         end
         cycles = 0;
         while (ddr3_we && cycles < drain_timeout) begin
            @(negedge clk);
            cycles++;
         end
         if (ddr3_we) begin
            $display("Timeout at %0t: the last DDR3 word was never accepted", $time);
            timed_out = 1'b1;
            errors++;
         end
      end
   endtask

   task automatic check_image();
      int shown;
      shown = 0;
      for (int i = 0; i < image_bytes; i++) begin
         if (mem_image[i] !== exp_image[i]) begin
            if (shown < 8) begin
               $display("Mismatch at %0t: image byte 0x%03h is 0x%02h, expected 0x%02h",
                        $time, i, mem_image[i], exp_image[i]);
            end
            shown++;
            errors++;
         end
      end
      for (int w = 0; w < word_count; w++) begin
         if (word_seen[w] != 1) begin
            $display("DDR3 word %0d was written %0d times instead of once", w, word_seen[w]);
            errors++;
         end
      end
      if (stray_writes != 0) begin
         $display("%0d DDR3 words were written outside the dump image", stray_writes);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int start_errors);
      if (errors == start_errors) begin
         pass_count++;
         $display("%s: ok", name);
      end else begin
         fail_count++;
         $display("%s: %0d errors", name, errors - start_errors);
      end
   endtask

   task automatic dump_after_reset();
      int start;
      start = errors;
      @(negedge clk);
      if (ddr3_we !== 1'b0 || dump_done !== 1'b0) begin
         $display("Mismatch at %0t: ddr3_we or dump_done is high after reset", $time);
         errors++;
      end
      run_dump(1'b0);
      if (!timed_out) check_image();
      finish_test("reset dump", start);
   endtask

   task automatic load_all_tables();
      int          start;
      logic [31:0] rnd;
      start = errors;
      for (int a = 0; a < image_bytes; a++) begin
         if (is_stored(11'(a))) begin
            rnd = $random(seed);
            write_byte(11'(a), rnd[7:0]);
         end
      end
      run_dump(1'b0);
      if (!timed_out) check_image();
      finish_test("full table load", start);
   endtask

   task automatic write_reserved_bytes();
      int          start;
      logic [31:0] rnd;
      start = errors;
      for (int a = 0; a < image_bytes; a++) begin
         if (!is_stored(11'(a))) begin
            rnd = $random(seed);
            write_byte(11'(a), rnd[7:0]);
         end
      end
      run_dump(1'b0);
      if (!timed_out) check_image();
      finish_test("reserved writes", start);
   endtask

   task automatic dump_under_back_pressure();
      int start;
      start = errors;
      run_dump(1'b1);
      if (!timed_out) check_image();
      if (stalls == 0) begin
         $display("ddr3_busy never held back a DDR3 word");
         errors++;
      end
      finish_test("back-pressure", start);
   endtask

   task automatic check_word_form();
      int start;
      start = errors;
      run_dump(1'b0);
      if (!timed_out) check_image();
      if (partial_writes != 0) begin
         $display("Mismatch at %0t: %0d words had byte enables missing", $time, partial_writes);
         errors++;
      end
      if (order_errors != 0 || word_total != word_count) begin
         $display("Mismatch at %0t: %0d words, %0d out of address order",
                  $time, word_total, order_errors);
         errors++;
      end
      finish_test("word form", start);
   endtask

   task automatic repeat_dump();
      int          start;
      logic [31:0] rnd;
      logic [10:0] picks [5];
      start = errors;
      picks = '{11'h027, 11'h132, 11'h20f, 11'h379, 11'h41d};
      for (int i = 0; i < image_bytes; i++) begin
         prev_image[i] = mem_image[i];
         changed[i]    = 1'b0;
      end
      foreach (picks[p]) begin
         rnd = $random(seed);
         changed[picks[p]] = 1'b1;
         write_byte(picks[p], exp_image[picks[p]] ^ (rnd[7:0] | 8'h01));
      end
      run_dump(1'b0);
      if (!timed_out) begin
         check_image();
         for (int i = 0; i < image_bytes; i++) begin
            if (changed[i] == (mem_image[i] === prev_image[i])) begin
               $display("Mismatch at %0t: byte 0x%03h changed=%0d but reads 0x%02h, was 0x%02h",
                        $time, i, changed[i], mem_image[i], prev_image[i]);
               errors++;
            end
         end
      end
      finish_test("repeat dump", start);
   endtask

   initial begin
      int cycles;
      ioctl_wr   = 1'b0;
      ioctl_addr = 11'd0;
      ioctl_dout = 8'd0;
      dump_start = 1'b0;
      ddr3_busy  = 1'b0;
      errors     = 0;
      pass_count = 0;
      fail_count = 0;
      timed_out  = 1'b0;
      hold_valid = 1'b0;
      reset_expected();
      cycles = 0;
      while (reset !== 1'b0 && cycles < reset_timeout) begin
         @(posedge clk);
         cycles++;
      end
      if (reset !== 1'b0) begin
         $display("Reset never released");
         timed_out = 1'b1;
         errors++;
      end
      if (!timed_out) dump_after_reset();
      if (!timed_out) load_all_tables();
      if (!timed_out) write_reserved_bytes();
      if (!timed_out) dump_under_back_pressure();
      if (!timed_out) check_word_form();
      if (!timed_out) repeat_dump();
      $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
      if (errors == 0 && fail_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* msx_debug_dump.f */
rtl/msx_pkg.sv
rtl/msx_config_loader.sv
rtl/msx_download_debug.sv
rtl/ddr3_byte_packer.sv
rtl/msx_debug_dump.sv
verification/tb_clock.sv
verification/tb_msx_debug_dump.sv
